// File: src/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // TLB geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = 3;
    localparam int VPN2_W      = 19;
    localparam int PFN_W       = 20;
    localparam int CACHE_W     = 3;
    // 4k pages, bit 12 picks the odd half of a pair
    localparam int PAGE_OFS_W  = 12;

    // segment starts
    localparam logic [31:0] KSEG0_BASE = 32'h8000_0000;
    localparam logic [31:0] KSEG1_BASE = 32'hA000_0000;
    localparam logic [31:0] KSEG2_BASE = 32'hC000_0000;

    localparam logic [CACHE_W-1:0] CACHE_CACHEABLE = 3'd3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map, byte offsets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int AXI_ADDR_W = 5;
    localparam logic [AXI_ADDR_W-1:0] REG_INDEX     = 5'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_ENTRY_HI  = 5'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_ENTRY_LO0 = 5'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_ENTRY_LO1 = 5'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_CONFIG    = 5'h10;
    localparam logic [AXI_ADDR_W-1:0] REG_COMMAND   = 5'h14;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // field positions inside the registers
    localparam int EHI_VPN2_LSB = 13;
    localparam int LO_PFN_LSB   = 6;
    localparam int LO_C_LSB     = 3;
    localparam int LO_V_BIT     = 1;
    localparam int CFG_K0_LSB   = 0;
    localparam int INDEX_P_BIT  = 31;

    // one half of an even/odd page pair
    typedef struct packed {
        logic [PFN_W-1:0]   pfn;
        logic [CACHE_W-1:0] c;
        logic               v;
    } tlb_lo_t;

    // nop covers every value that is not an opcode
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_TLBWI = 2'd1,
        CMD_TLBP  = 2'd2
    } tlb_cmd_e;

    typedef enum logic [1:0] {
        SEG_MAPPED,
        SEG_KSEG0,
        SEG_KSEG1
    } seg_e;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        RESP
    } axil_state_e;

endpackage

`default_nettype wire

// File: src/mmu_if.sv
`timescale 1ns/1ps
`default_nettype none

// maintenance path, register block to TLB array
interface tlb_maint_if import mmu_pkg::*; ();
    logic                 we;
    logic [TLB_IDX_W-1:0] index;
    logic [VPN2_W-1:0]    vpn2;
    tlb_lo_t              lo0;
    tlb_lo_t              lo1;
    logic [VPN2_W-1:0]    probe_vpn2;
    logic                 probe_hit;
    logic [TLB_IDX_W-1:0] probe_index;

    modport ctrl  (output we, index, vpn2, lo0, lo1, probe_vpn2,
                   input  probe_hit, probe_index);
    modport array (input  we, index, vpn2, lo0, lo1, probe_vpn2,
                   output probe_hit, probe_index);
endinterface

// translation lookup, combinational on both sides
interface tlb_lookup_if import mmu_pkg::*; ();
    logic              odd_page;
    logic [VPN2_W-1:0] vpn2;
    logic              hit;
    tlb_lo_t           page;

    modport trans (output vpn2, odd_page, input  hit, page);
    modport array (input  vpn2, odd_page, output hit, page);
endinterface

`default_nettype wire

// File: src/mmu_axil_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_axil_ctrl import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [AXI_ADDR_W-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [31:0]           s_wdata,
    input  logic [3:0]            s_wstrb,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  logic [AXI_ADDR_W-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [31:0]           s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    output logic [CACHE_W-1:0]    k0,
    tlb_maint_if.ctrl             maint
);
    axil_state_e          state;
    tlb_cmd_e             cmd_q;
    logic                 wr_accept;
    logic                 index_p;
    logic [TLB_IDX_W-1:0] index_idx;
    logic [VPN2_W-1:0]    entry_vpn2;
    tlb_lo_t              entry_lo0;
    tlb_lo_t              entry_lo1;
    logic [31:0]          rd_word;
    logic [1:0]           rd_resp;

    function automatic tlb_lo_t word_to_lo(input logic [31:0] w);
        tlb_lo_t lo;
        lo.pfn = w[LO_PFN_LSB +: PFN_W];
        lo.c   = w[LO_C_LSB +: CACHE_W];
        lo.v   = w[LO_V_BIT];
        return lo;
    endfunction

    function automatic logic [31:0] lo_to_word(input tlb_lo_t lo);
        logic [31:0] w;
        w = '0;
        w[LO_PFN_LSB +: PFN_W] = lo.pfn;
        w[LO_C_LSB +: CACHE_W] = lo.c;
        w[LO_V_BIT]            = lo.v;
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // aw and w are taken together and byte strobes are ignored
    assign wr_accept = (state == IDLE) && s_awvalid && s_wvalid;
    assign s_awready = wr_accept;
    assign s_wready  = wr_accept;
    assign s_bvalid  = (state == RESP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            cmd_q      <= CMD_NOP;
            s_bresp    <= RESP_OKAY;
            index_p    <= 1'b0;
            index_idx  <= '0;
            entry_vpn2 <= '0;
            entry_lo0  <= '0;
            entry_lo1  <= '0;
            k0         <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_accept) begin
                        s_bresp <= RESP_OKAY;
                        state   <= RESP;
                        case (s_awaddr)
                            // P is status only
                            REG_INDEX:     index_idx  <= s_wdata[TLB_IDX_W-1:0];
                            REG_ENTRY_HI:  entry_vpn2 <= s_wdata[EHI_VPN2_LSB +: VPN2_W];
                            REG_ENTRY_LO0: entry_lo0  <= word_to_lo(s_wdata);
                            REG_ENTRY_LO1: entry_lo1  <= word_to_lo(s_wdata);
                            REG_CONFIG:    k0         <= s_wdata[CFG_K0_LSB +: CACHE_W];
                            REG_COMMAND: begin
                                cmd_q <= (s_wdata[31:2] == '0) ? tlb_cmd_e'(s_wdata[1:0])
                                                               : CMD_NOP;
                                state <= EXEC;
                            end
                            default:       s_bresp    <= RESP_SLVERR;
                        endcase
                    end
                end
                EXEC: begin
                    // probe miss keeps the old index field
                    if (cmd_q == CMD_TLBP) begin
                        index_p <= !maint.probe_hit;
                        if (maint.probe_hit) begin
                            index_idx <= maint.probe_index;
                        end
                    end
                    state <= RESP;
                end
                RESP: begin
                    if (s_bready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign maint.we         = (state == EXEC) && (cmd_q == CMD_TLBWI);
    assign maint.index      = index_idx;
    assign maint.vpn2       = entry_vpn2;
    assign maint.lo0        = entry_lo0;
    assign maint.lo1        = entry_lo1;
    assign maint.probe_vpn2 = entry_vpn2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (s_araddr)
            REG_INDEX: begin
                rd_word[INDEX_P_BIT]     = index_p;
                rd_word[TLB_IDX_W-1:0]   = index_idx;
            end
            REG_ENTRY_HI:  rd_word[EHI_VPN2_LSB +: VPN2_W] = entry_vpn2;
            REG_ENTRY_LO0: rd_word = lo_to_word(entry_lo0);
            REG_ENTRY_LO1: rd_word = lo_to_word(entry_lo1);
            REG_CONFIG:    rd_word[CFG_K0_LSB +: CACHE_W] = k0;
            REG_COMMAND:   rd_word = '0;
            default:       rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
            s_rdata   <= '0;
            s_rresp   <= RESP_OKAY;
        end else if (s_arvalid && s_arready) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b1;
            s_rdata   <= rd_word;
            s_rresp   <= rd_resp;
        end else if (!s_rvalid || s_rready) begin
            s_arready <= 1'b1;
            s_rvalid  <= 1'b0;
        end
    end

    // response channels hold their beat until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp));
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp));
    // the write pulse comes only from the cycle after a COMMAND accept
    a_we_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        maint.we |-> $past(wr_accept) && $past(s_awaddr) == REG_COMMAND && !s_bvalid);

endmodule

`default_nettype wire

// File: src/tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb import mmu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    tlb_maint_if.array maint,
    tlb_lookup_if.array lookup
);
    logic [VPN2_W-1:0]    vpn2_q [TLB_ENTRIES];
    tlb_lo_t              lo0_q  [TLB_ENTRIES];
    tlb_lo_t              lo1_q  [TLB_ENTRIES];
    logic [TLB_IDX_W:0]   look_res;
    logic [TLB_IDX_W:0]   probe_res;
    logic [TLB_IDX_W-1:0] look_sel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                vpn2_q[i] <= '0;
                lo0_q[i]  <= '0;
                lo1_q[i]  <= '0;
            end
        end else if (maint.we) begin
            vpn2_q[maint.index] <= maint.vpn2;
            lo0_q[maint.index]  <= maint.lo0;
            lo1_q[maint.index]  <= maint.lo1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // associative match
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // returns {hit, index} and scans down so the lowest index wins
    function automatic logic [TLB_IDX_W:0] find_lowest(input logic [VPN2_W-1:0] key);
        logic [TLB_IDX_W:0] res;
        res = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (vpn2_q[i] == key) begin
                res = {1'b1, TLB_IDX_W'(i)};
            end
        end
        return res;
    endfunction

    // translation and probe get their own comparators
    always_comb begin
        look_res  = find_lowest(lookup.vpn2);
        probe_res = find_lowest(maint.probe_vpn2);
    end

    assign look_sel    = look_res[TLB_IDX_W-1:0];
    assign lookup.hit  = look_res[TLB_IDX_W];
    // v travels with the page and the caller decides what v = 0 means
    assign lookup.page = lookup.odd_page ? lo1_q[look_sel] : lo0_q[look_sel];

    assign maint.probe_hit   = probe_res[TLB_IDX_W];
    assign maint.probe_index = probe_res[TLB_IDX_W-1:0];

    a_hit_matches: assert property (@(posedge clk) disable iff (!rst_n)
        lookup.hit |-> vpn2_q[look_sel] == lookup.vpn2);

endmodule

`default_nettype wire

// File: src/addr_trans.sv
`timescale 1ns/1ps
`default_nettype none

module addr_trans import mmu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               trans_valid,
    input  logic [31:0]        virt_addr,
    input  logic [CACHE_W-1:0] k0,
    tlb_lookup_if.trans        lookup,
    output logic               out_valid,
    output logic [31:0]        phy_addr,
    output logic               cached,
    output logic               tlb_mapped,
    output logic               tlb_miss
);
    seg_e        seg;
    logic        page_ok;
    logic [31:0] phy_d;
    logic        cached_d;

    // kuseg, kseg2 and kseg3 all go through the TLB
    always_comb begin
        if (virt_addr >= KSEG0_BASE && virt_addr < KSEG1_BASE) begin
            seg = SEG_KSEG0;
        end else if (virt_addr >= KSEG1_BASE && virt_addr < KSEG2_BASE) begin
            seg = SEG_KSEG1;
        end else begin
            seg = SEG_MAPPED;
        end
    end

    assign lookup.vpn2     = virt_addr[31 -: VPN2_W];
    assign lookup.odd_page = virt_addr[PAGE_OFS_W];
    assign page_ok         = lookup.hit && lookup.page.v;

    always_comb begin
        case (seg)
            SEG_KSEG0: begin
                phy_d    = virt_addr - KSEG0_BASE;
                cached_d = (k0 == CACHE_CACHEABLE);
            end
            SEG_KSEG1: begin
                phy_d    = virt_addr - KSEG1_BASE;
                cached_d = 1'b0;
            end
            default: begin
                // miss gives zero address and uncached
                phy_d    = page_ok ? {lookup.page.pfn, virt_addr[PAGE_OFS_W-1:0]} : '0;
                cached_d = page_ok && (lookup.page.c == CACHE_CACHEABLE);
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= trans_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (trans_valid) begin
            phy_addr   <= phy_d;
            cached     <= cached_d;
            tlb_mapped <= (seg == SEG_MAPPED);
            tlb_miss   <= (seg == SEG_MAPPED) && !page_ok;
        end
    end

    // a miss only ever comes from an address outside kseg0 and kseg1
    a_miss_mapped: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && tlb_miss |-> tlb_mapped && $past(virt_addr[31:30]) != 2'b10
                                  && phy_addr == '0 && !cached);

endmodule

`default_nettype wire

// File: src/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // AXI4-Lite register port
    input  logic [AXI_ADDR_W-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [31:0]           s_wdata,
    input  logic [3:0]            s_wstrb,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  logic [AXI_ADDR_W-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [31:0]           s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    // translation port
    input  logic                  trans_valid,
    input  logic [31:0]           virt_addr,
    output logic                  out_valid,
    output logic [31:0]           phy_addr,
    output logic                  cached,
    output logic                  tlb_mapped,
    output logic                  tlb_miss
);
    logic [CACHE_W-1:0] k0;

    tlb_maint_if  maint_if ();
    tlb_lookup_if lookup_if ();

    mmu_axil_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .k0        (k0),
        .maint     (maint_if.ctrl)
    );

    tlb i_tlb (
        .clk    (clk),
        .rst_n  (rst_n),
        .maint  (maint_if.array),
        .lookup (lookup_if.array)
    );

    addr_trans i_trans (
        .clk         (clk),
        .rst_n       (rst_n),
        .trans_valid (trans_valid),
        .virt_addr   (virt_addr),
        .k0          (k0),
        .lookup      (lookup_if.trans),
        .out_valid   (out_valid),
        .phy_addr    (phy_addr),
        .cached      (cached),
        .tlb_mapped  (tlb_mapped),
        .tlb_miss    (tlb_miss)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mmu import mmu_pkg::*; ();

    // AXI transfers plus translations over the whole run
    localparam int N_OPS  = 180;
    localparam int N_RAND = 12;

    typedef struct packed {
        logic [31:0] phy;
        logic        cached;
        logic        mapped;
        logic        miss;
    } trans_exp_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [AXI_ADDR_W-1:0] s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    logic [31:0]           s_wdata;
    logic [3:0]            s_wstrb;
    logic                  s_wvalid;
    logic                  s_wready;
    logic [1:0]            s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    logic [AXI_ADDR_W-1:0] s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    logic [31:0]           s_rdata;
    logic [1:0]            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;
    logic                  trans_valid;
    logic [31:0]           virt_addr;
    logic                  out_valid;
    logic [31:0]           phy_addr;
    logic                  cached;
    logic                  tlb_mapped;
    logic                  tlb_miss;

    integer seed = 32'h14e3e082;

    // shadow of the register file and the TLB
    logic [VPN2_W-1:0]    sh_vpn2 [TLB_ENTRIES];
    tlb_lo_t              sh_pg0  [TLB_ENTRIES];
    tlb_lo_t              sh_pg1  [TLB_ENTRIES];
    logic [TLB_IDX_W-1:0] sh_idx;
    logic                 sh_p;
    logic [VPN2_W-1:0]    sh_hi;
    tlb_lo_t              sh_lo0;
    tlb_lo_t              sh_lo1;
    logic [CACHE_W-1:0]   sh_k0;
    logic [VPN2_W-1:0]    used_vpn2 [TLB_ENTRIES];
    trans_exp_t           exp_q [$];

    mmu_top i_dut (.*);

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [31:0] lo_word(input tlb_lo_t lo);
        return {6'd0, lo.pfn, lo.c, 1'b0, lo.v, 1'b0};
    endfunction

    function automatic tlb_lo_t rand_page(input logic v);
        tlb_lo_t     lo;
        logic [31:0] r;
        r      = rand32();
        lo.pfn = r[19:0];
        lo.c   = r[22:20];
        lo.v   = v;
        return lo;
    endfunction

    function automatic logic in_tlb(input logic [VPN2_W-1:0] vpn);
        logic found;
        found = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            found = found | (sh_vpn2[i] == vpn);
        end
        return found;
    endfunction

    // top three bits 100 and 101 would land in kseg0/kseg1
    function automatic logic [VPN2_W-1:0] rand_mapped_vpn2();
        logic [VPN2_W-1:0] vpn;
        vpn = rand32() >> 13;
        if (vpn[18:17] == 2'b10) begin
            vpn[18] = 1'b0;
        end
        return vpn;
    endfunction

    function automatic logic [VPN2_W-1:0] absent_vpn2();
        logic [VPN2_W-1:0] vpn;
        do begin
            vpn = rand_mapped_vpn2();
        end while (in_tlb(vpn));
        return vpn;
    endfunction

    function automatic trans_exp_t ref_translate(input logic [31:0] va);
        trans_exp_t e;
        tlb_lo_t    pg;
        logic       found;
        e     = '0;
        pg    = '0;
        found = 1'b0;
        case (va[31:29])
            3'b100: begin
                e.phy    = {3'b000, va[28:0]};
                e.cached = (sh_k0 == CACHE_CACHEABLE);
            end
            3'b101: e.phy = {3'b000, va[28:0]};
            default: begin
                e.mapped = 1'b1;
                for (int i = 0; i < TLB_ENTRIES; i++) begin
                    if (!found && sh_vpn2[i] == va[31:13]) begin
                        found = 1'b1;
                        pg    = va[12] ? sh_pg1[i] : sh_pg0[i];
                    end
                end
                if (found && pg.v) begin
                    e.phy    = {pg.pfn, va[11:0]};
                    e.cached = (pg.c == CACHE_CACHEABLE);
                end else begin
                    e.miss = 1'b1;
                end
            end
        endcase
        return e;
    endfunction

    function automatic logic addr_known(input logic [AXI_ADDR_W-1:0] a);
        return a inside {REG_INDEX, REG_ENTRY_HI, REG_ENTRY_LO0, REG_ENTRY_LO1,
                         REG_CONFIG, REG_COMMAND};
    endfunction

    function automatic logic [31:0] reg_expect(input logic [AXI_ADDR_W-1:0] a);
        case (a)
            REG_INDEX:     return {sh_p, 28'd0, sh_idx};
            REG_ENTRY_HI:  return {sh_hi, 13'd0};
            REG_ENTRY_LO0: return lo_word(sh_lo0);
            REG_ENTRY_LO1: return lo_word(sh_lo1);
            REG_CONFIG:    return {29'd0, sh_k0};
            default:       return 32'd0;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR %0t: %s got 0x%08h expected 0x%08h", $time, field, got, exp);
        $display("test failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_trans(input trans_exp_t e, input logic [31:0] phy, input logic c,
                               input logic mapped, input logic miss);
        if (phy !== e.phy) report_mismatch("phy_addr", phy, e.phy);
        if (c !== e.cached) report_mismatch("cached", {31'd0, c}, {31'd0, e.cached});
        if (mapped !== e.mapped) begin
            report_mismatch("tlb_mapped", {31'd0, mapped}, {31'd0, e.mapped});
        end
        if (miss !== e.miss) report_mismatch("tlb_miss", {31'd0, miss}, {31'd0, e.miss});
    endtask

    task automatic check_read(input logic [31:0] got_d, input logic [1:0] got_r,
                              input logic [31:0] exp_d, input logic [1:0] exp_r);
        if (got_r !== exp_r) report_mismatch("rresp", {30'd0, got_r}, {30'd0, exp_r});
        if (got_d !== exp_d) report_mismatch("rdata", got_d, exp_d);
    endtask

    task automatic check_bresp(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) report_mismatch("bresp", {30'd0, got}, {30'd0, exp});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int delay;
        @(posedge clk);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wvalid  <= 1'b1;
        do @(posedge clk); while (!(s_awready && s_wready));
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        delay = int'(rand32() % 4);
        repeat (delay) @(posedge clk);
        s_bready <= 1'b1;
        do @(posedge clk); while (!s_bvalid);
        resp = s_bresp;
        s_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        @(posedge clk);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        do @(posedge clk); while (!s_arready);
        s_arvalid <= 1'b0;
        delay = int'(rand32() % 4);
        repeat (delay) @(posedge clk);
        s_rready <= 1'b1;
        do @(posedge clk); while (!s_rvalid);
        data = s_rdata;
        resp = s_rresp;
        s_rready <= 1'b0;
    endtask

    task automatic reg_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        logic       found;
        axil_write(addr, data, resp);
        check_bresp(resp, addr_known(addr) ? RESP_OKAY : RESP_SLVERR);
        found = 1'b0;
        case (addr)
            // P bit is read only
            REG_INDEX:     sh_idx = data[2:0];
            REG_ENTRY_HI:  sh_hi  = data[31:13];
            REG_ENTRY_LO0: sh_lo0 = '{pfn: data[25:6], c: data[5:3], v: data[1]};
            REG_ENTRY_LO1: sh_lo1 = '{pfn: data[25:6], c: data[5:3], v: data[1]};
            REG_CONFIG:    sh_k0  = data[2:0];
            REG_COMMAND: begin
                if (data == 32'd1) begin
                    sh_vpn2[sh_idx] = sh_hi;
                    sh_pg0[sh_idx]  = sh_lo0;
                    sh_pg1[sh_idx]  = sh_lo1;
                end else if (data == 32'd2) begin
                    for (int i = 0; i < TLB_ENTRIES; i++) begin
                        if (!found && sh_vpn2[i] == sh_hi) begin
                            found  = 1'b1;
                            sh_idx = TLB_IDX_W'(i);
                        end
                    end
                    sh_p = !found;
                end
            end
            default: ;
        endcase
    endtask

    task automatic reg_read_check(input logic [AXI_ADDR_W-1:0] addr);
        logic [31:0] d;
        logic [1:0]  r;
        axil_read(addr, d, r);
        check_read(d, r, reg_expect(addr), addr_known(addr) ? RESP_OKAY : RESP_SLVERR);
    endtask

    task automatic map_entry(input logic [TLB_IDX_W-1:0] idx, input logic [VPN2_W-1:0] vpn,
                             input tlb_lo_t lo0, input tlb_lo_t lo1);
        reg_write(REG_INDEX, {29'd0, idx});
        reg_write(REG_ENTRY_HI, {vpn, 13'(rand32())});
        reg_write(REG_ENTRY_LO0, lo_word(lo0));
        reg_write(REG_ENTRY_LO1, lo_word(lo1));
        reg_write(REG_COMMAND, 32'd1);
    endtask

    // one translation address per edge
    task automatic issue_trans(input logic [31:0] va);
        @(posedge clk);
        trans_valid <= 1'b1;
        virt_addr   <= va;
        exp_q.push_back(ref_translate(va));
    endtask

    task automatic end_trans();
        @(posedge clk);
        trans_valid <= 1'b0;
    endtask

    task automatic run_unmapped();
        for (int n = 0; n < N_RAND; n++) begin
            issue_trans(KSEG0_BASE | (rand32() & 32'h1FFF_FFFF));
            issue_trans(KSEG1_BASE | (rand32() & 32'h1FFF_FFFF));
        end
        end_trans();
    endtask

    always @(posedge clk) begin : compare
        trans_exp_t e;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERR %0t: out_valid with no translation pending", $time);
                $display("test failed");
                $fatal(1, "unexpected result");
            end else begin
                e = exp_q.pop_front();
                check_trans(e, phy_addr, cached, tlb_mapped, tlb_miss);
            end
        end
    end

    initial begin : watchdog
        #((N_OPS * 40 + 1000) * 20);
        $display("timeout: the simulation hung with operations still pending");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main
        logic [VPN2_W-1:0] vpn;
        int                k;
        rst_n       <= 1'b0;
        s_awaddr    <= '0;
        s_awvalid   <= 1'b0;
        s_wdata     <= '0;
        s_wstrb     <= 4'hF;
        s_wvalid    <= 1'b0;
        s_bready    <= 1'b0;
        s_araddr    <= '0;
        s_arvalid   <= 1'b0;
        s_rready    <= 1'b0;
        trans_valid <= 1'b0;
        virt_addr   <= '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            sh_vpn2[i] = '0;
            sh_pg0[i]  = '0;
            sh_pg1[i]  = '0;
        end
        sh_idx = '0;
        sh_p   = 1'b0;
        sh_hi  = '0;
        sh_lo0 = '0;
        sh_lo1 = '0;
        sh_k0  = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // fixed segments with k0 cacheable and then uncached
        reg_write(REG_CONFIG, 32'd3);
        run_unmapped();
        reg_write(REG_CONFIG, 32'hFFFF_FFFA);
        run_unmapped();

        // fill every entry and then issue back-to-back hits
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            used_vpn2[i] = rand_mapped_vpn2();
            map_entry(TLB_IDX_W'(i), used_vpn2[i], rand_page(1'b1), rand_page(1'b1));
        end
        for (int n = 0; n < 4 * TLB_ENTRIES; n++) begin
            k = int'(rand32() % TLB_ENTRIES);
            issue_trans({used_vpn2[k], 13'(rand32())});
        end
        end_trans();

        // misses on an absent pair and an invalid half, then a duplicate vpn2
        vpn = absent_vpn2();
        issue_trans({vpn, 13'h0000});
        issue_trans({vpn, 13'h1ABC});
        end_trans();
        map_entry(3'd5, used_vpn2[5], rand_page(1'b0), rand_page(1'b1));
        issue_trans({used_vpn2[5], 13'h0123});
        issue_trans({used_vpn2[5], 13'h1123});
        end_trans();
        map_entry(3'd6, used_vpn2[2], rand_page(1'b1), rand_page(1'b1));
        used_vpn2[6] = used_vpn2[2];
        issue_trans({used_vpn2[2], 13'h0456});
        issue_trans({used_vpn2[2], 13'h1456});
        end_trans();

        // probe a hit and the duplicate and then an absent vpn2
        reg_write(REG_ENTRY_HI, {used_vpn2[3], 13'h1FFF});
        reg_write(REG_COMMAND, 32'd2);
        reg_read_check(REG_INDEX);
        reg_write(REG_ENTRY_HI, {used_vpn2[6], 13'd0});
        reg_write(REG_COMMAND, 32'd2);
        reg_read_check(REG_INDEX);
        reg_write(REG_ENTRY_HI, {absent_vpn2(), 13'd0});
        reg_write(REG_COMMAND, 32'd2);
        reg_read_check(REG_INDEX);

        // register readback under the field masks
        for (int n = 0; n < 2; n++) begin
            reg_write(REG_INDEX, rand32());
            reg_read_check(REG_INDEX);
            reg_write(REG_ENTRY_HI, rand32());
            reg_read_check(REG_ENTRY_HI);
            reg_write(REG_ENTRY_LO0, rand32());
            reg_read_check(REG_ENTRY_LO0);
            reg_write(REG_ENTRY_LO1, rand32());
            reg_read_check(REG_ENTRY_LO1);
            reg_write(REG_CONFIG, rand32());
            reg_read_check(REG_CONFIG);
        end
        reg_write(REG_COMMAND, 32'd3);
        reg_read_check(REG_COMMAND);
        reg_write(5'h18, rand32());
        reg_read_check(5'h18);
        reg_write(5'h06, rand32());
        reg_read_check(5'h1C);

        // unknown writes leave every register untouched
        reg_read_check(REG_INDEX);
        reg_read_check(REG_ENTRY_HI);
        reg_read_check(REG_ENTRY_LO0);
        reg_read_check(REG_ENTRY_LO1);
        reg_read_check(REG_CONFIG);

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d translation results never arrived", exp_q.size());
            $display("test failed");
            $fatal(1, "missing results");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
src/mmu_pkg.sv
src/mmu_if.sv
src/mmu_axil_ctrl.sv
src/tlb.sv
src/addr_trans.sv
src/mmu_top.sv
testbench/tb_mmu.sv

// File: Makefile
SRCS := $(wildcard src/*.sv) testbench/tb_mmu.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_mmu: $(SRCS) tb.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu -f tb.f -o Vtb_mmu

run: obj_dir/Vtb_mmu
	./obj_dir/Vtb_mmu | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
